/* fetch_defs.svh */
// sizing macros shared by the prefetch RTL and its testbench through include
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

//////////////////////////////////////////////////
// fifo sizing
//////////////////////////////////////////////////

// number of 32-bit words held by the fetch fifo
`define FETCH_FIFO_DEPTH 4

// fill count width, must hold 0 up to the depth
`define FETCH_CNT_W 3

//////////////////////////////////////////////////
// memory side
//////////////////////////////////////////////////

// requests allowed in flight at once
`define FETCH_MAX_OUTSTANDING 2

// first fetch address after reset
`define FETCH_BOOT_ADDR 32'h0000_0080

`endif

/* fetch_pkg.sv */
// types and helper function shared by the prefetch RTL and its testbench
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////
  // instruction memory port
  //////////////////////////////////////////////////

  // request side, addr is always word aligned
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } mem_req_t;

  // response side
  // gnt accepts the request of this cycle, rvalid carries rdata
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  //////////////////////////////////////////////////
  // instruction output
  //////////////////////////////////////////////////

  // compressed instr only uses bits 15:0
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
  } instr_out_t;

  // one fetched word, seen whole or as two half-words
  typedef union packed {
    logic [31:0] full;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } instr_word_u;

  // rv compressed encoding: low two bits other than 2'b11
  function automatic logic is_compressed(input logic [15:0] half_word);
    return half_word[1:0] != 2'b11;
  endfunction

endpackage

`default_nettype wire

/* fetch_fifo.sv */
// word buffer and aligner between memory responses and the instruction output
`default_nettype none
`include "fetch_defs.svh"

module fetch_fifo (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // branch restarts the stream at branch_addr_i
  input  wire logic                   branch_i,
  input  wire logic [31:0]            branch_addr_i,
  // words coming back from memory
  input  wire logic [31:0]            in_rdata_i,
  input  wire logic                   in_valid_i,
  output logic [`FETCH_CNT_W-1:0]     in_cnt_o,
  // aligned instruction out
  output logic                        out_valid_o,
  input  wire logic                   out_ready_i,
  output fetch_pkg::instr_out_t       out_o
);

  // entry 0 is the head feeding the output
  logic [`FETCH_FIFO_DEPTH-1:0][31:0] rdata_q, rdata_int, rdata_n;
  logic [`FETCH_FIFO_DEPTH-1:0]       valid_q, valid_int, valid_n;
  logic                               placed;

  // pc of the instruction at the head, bit 1 marks the upper half
  logic [31:0]                        addr_q, addr_n, addr_incr;
  logic [`FETCH_CNT_W-1:0]            fill;

  fetch_pkg::instr_word_u             head_w, next_w;
  logic                               head_valid, pair_valid;
  logic                               lo_compressed, hi_compressed;
  logic                               unaligned;
  logic                               pop_word;

  //////////////////////////////////////////////////
  // head and next word, bypass when empty
  //////////////////////////////////////////////////

  assign head_w.full = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign next_w.full = valid_q[1] ? rdata_q[1] : in_rdata_i;

  assign head_valid = valid_q[0] || in_valid_i;
  // second word present, either stored or arriving behind a stored head
  assign pair_valid = valid_q[1] || (valid_q[0] && in_valid_i);

  assign lo_compressed = fetch_pkg::is_compressed(head_w.half.lo);
  assign hi_compressed = fetch_pkg::is_compressed(head_w.half.hi);
  assign unaligned     = addr_q[1];

  //////////////////////////////////////////////////
  // aligner
  //////////////////////////////////////////////////

  always_comb begin
    out_o.addr = addr_q;
    if (unaligned) begin
      // upper half of head joined with lower half of next word
      out_o.instr = {next_w.half.lo, head_w.half.hi};
      // full instr across words waits for both halves
      out_valid_o = head_valid && (hi_compressed || pair_valid);
    end else begin
      out_o.instr = head_w.full;
      out_valid_o = head_valid;
    end
  end

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  // incoming word goes to the first free entry
  always_comb begin
    rdata_int = rdata_q;
    valid_int = valid_q;
    placed    = 1'b0;
    for (int i = 0; i < `FETCH_FIFO_DEPTH; i++) begin
      if (in_valid_i && !valid_q[i] && !placed) begin
        rdata_int[i] = in_rdata_i;
        valid_int[i] = 1'b1;
        placed       = 1'b1;
      end
    end
  end

  // entries are filled from 0 upward, so a popcount is the fill level
  always_comb begin
    fill = '0;
    for (int i = 0; i < `FETCH_FIFO_DEPTH; i++) begin
      if (valid_q[i]) begin
        fill = fill + 1'b1;
      end
    end
  end

  // reads empty during a branch so the controller refetches at once
  assign in_cnt_o = branch_i ? '0 : fill;

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  // head word is done unless an aligned compressed instr leaves its upper half
  assign pop_word = out_valid_o && out_ready_i && (unaligned || !lo_compressed);

  always_comb begin
    addr_n = addr_q;
    if (out_valid_o && out_ready_i) begin
      if (unaligned) begin
        // full instr here ends in the lower half of the next word
        addr_n = hi_compressed ? addr_incr : {addr_incr[31:2], 2'b10};
      end else if (lo_compressed) begin
        addr_n = {addr_q[31:2], 2'b10};
      end else begin
        addr_n = addr_incr;
      end
    end
  end

  always_comb begin
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (pop_word) begin
      for (int i = 0; i < `FETCH_FIFO_DEPTH - 1; i++) begin
        rdata_n[i] = rdata_int[i + 1];
      end
      valid_n = valid_int >> 1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q  <= `FETCH_BOOT_ADDR;
      valid_q <= '0;
    end else if (branch_i) begin
      // drop everything, first word after this belongs to the target
      addr_q  <= branch_addr_i;
      valid_q <= '0;
    end else begin
      addr_q  <= addr_n;
      valid_q <= valid_n;
    end
  end

  // word storage, qualified by valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

endmodule

`default_nettype wire

/* fetch_ctrl_fsm.sv */
// fetch controller that issues word requests to instruction memory and follows branches
`default_nettype none
`include "fetch_defs.svh"

module fetch_ctrl_fsm (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // branch target, half-word aligned
  input  wire logic                   branch_i,
  input  wire logic [31:0]            branch_addr_i,
  // occupancy of the fetch path
  input  wire logic [`FETCH_CNT_W-1:0] fifo_cnt_i,
  input  wire logic [1:0]             outstanding_i,
  // memory handshake
  input  wire logic                   gnt_i,
  output fetch_pkg::mem_req_t         mem_req_o
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT_ROOM
  } state_e;

  state_e       state_q, state_n;

  // next word address to request
  logic [31:0]  addr_q;
  logic [3:0]   fill;
  logic         room;
  logic         req;

  //////////////////////////////////////////////////
  // room check
  //////////////////////////////////////////////////

  // stored words plus words still to arrive must fit the fifo
  assign fill = {1'b0, fifo_cnt_i} + {2'b00, outstanding_i};

  assign room = (fill < 4'(`FETCH_FIFO_DEPTH)) &&
                (outstanding_i < 2'(`FETCH_MAX_OUTSTANDING));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    case (state_q)
      // one quiet cycle out of reset
      IDLE:      state_n = FETCH;
      FETCH:     if (!room) state_n = WAIT_ROOM;
      WAIT_ROOM: if (room) state_n = FETCH;
      default:   state_n = IDLE;
    endcase
    // a branch always restarts fetching
    if (branch_i) begin
      state_n = FETCH;
    end
  end

  // no request in the branch cycle, the old address is stale
  assign req = (state_q == FETCH) && room && !branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////////////////////////
  // fetch address
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= `FETCH_BOOT_ADDR;
    end else if (branch_i) begin
      // word holding the target, the fifo picks the half
      addr_q <= {branch_addr_i[31:2], 2'b00};
    end else if (req && gnt_i) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = addr_q;

endmodule

`default_nettype wire

/* fetch_outstanding_cnt.sv */
// tracks requests in flight and filters responses made stale by a branch
`default_nettype none

module fetch_outstanding_cnt (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic branch_i,
  // memory strobes
  input  wire logic req_i,
  input  wire logic gnt_i,
  input  wire logic rvalid_i,
  // to controller and fifo
  output logic [1:0] outstanding_o,
  output logic       fifo_valid_o
);

  logic [1:0] cnt_q, cnt_n;
  // responses still to discard after a branch
  logic [1:0] drop_q;
  logic       granted;

  //////////////////////////////////////////////////
  // in-flight count
  //////////////////////////////////////////////////

  assign granted = req_i && gnt_i;

  // plus one per grant, minus one per response
  assign cnt_n = cnt_q + {1'b0, granted} - {1'b0, rvalid_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      drop_q <= '0;
    end else begin
      cnt_q <= cnt_n;
      if (branch_i) begin
        // everything pending after this edge belongs to the old stream
        drop_q <= cnt_n;
      end else if (rvalid_i && (drop_q != 2'd0)) begin
        drop_q <= drop_q - 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // response filter
  //////////////////////////////////////////////////

  // a response in the branch cycle is stale as well
  assign fifo_valid_o  = rvalid_i && (drop_q == 2'd0) && !branch_i;
  assign outstanding_o = cnt_q;

endmodule

`default_nettype wire

/* prefetch_buffer.sv */
// prefetch top connecting controller, request counter and fifo to memory and output
`default_nettype none
`include "fetch_defs.svh"

module prefetch_buffer (
  input  wire logic                clk,
  input  wire logic                rst_n,

  // branch from the core, one-cycle pulse
  input  wire logic                branch_i,
  input  wire logic [31:0]         branch_addr_i,

  // instruction memory port
  output fetch_pkg::mem_req_t      mem_req_o,
  input  wire fetch_pkg::mem_rsp_t mem_rsp_i,

  // aligned instruction stream
  output logic                     instr_valid_o,
  input  wire logic                instr_ready_i,
  output fetch_pkg::instr_out_t    instr_o
);

  logic [1:0]              outstanding;
  logic [`FETCH_CNT_W-1:0] fifo_cnt;
  logic                    fifo_valid;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  fetch_ctrl_fsm u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fifo_cnt_i    (fifo_cnt),
    .outstanding_i (outstanding),
    .gnt_i         (mem_rsp_i.gnt),
    .mem_req_o     (mem_req_o)
  );

  // sees the request actually driven to memory
  fetch_outstanding_cnt u_cnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .req_i         (mem_req_o.req),
    .gnt_i         (mem_rsp_i.gnt),
    .rvalid_i      (mem_rsp_i.rvalid),
    .outstanding_o (outstanding),
    .fifo_valid_o  (fifo_valid)
  );

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  fetch_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .in_rdata_i    (mem_rsp_i.rdata),
    .in_valid_i    (fifo_valid),
    .in_cnt_o      (fifo_cnt),
    .out_valid_o   (instr_valid_o),
    .out_ready_i   (instr_ready_i),
    .out_o         (instr_o)
  );

endmodule

`default_nettype wire

/* tb_prefetch_buffer.sv */
// self-checking testbench for prefetch_buffer that reads prefetch_input.txt from the project root
`default_nettype none
`include "fetch_defs.svh"

module tb_prefetch_buffer;

  localparam int IMAGE_WORDS   = 64;
  localparam int BRANCH_RECS   = 8;
  localparam int FINAL_ACCEPTS = 16;
  localparam int CYCLE_LIMIT   = 200 * BRANCH_RECS + 400;

  logic                  clk;
  logic                  rst_n;
  logic                  branch;
  logic [31:0]           branch_addr;
  fetch_pkg::mem_req_t   mem_req;
  fetch_pkg::mem_rsp_t   mem_rsp;
  logic                  instr_valid;
  logic                  instr_ready;
  fetch_pkg::instr_out_t instr;

  // memory image, then branch records of accept count and target
  logic [31:0] image [0:IMAGE_WORDS + 2 * BRANCH_RECS - 1];

  // memory model keeps responses in grant order
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          in_flight;

  // reference model and run state
  logic [31:0]           exp_pc;
  logic [31:0]           exp_word;
  logic [15:0]           lo_half;
  logic [31:0]           next_target;
  fetch_pkg::instr_out_t held;
  logic                  hold_armed;
  logic                  need_branch;
  logic                  seen_req;
  logic                  done;
  int                    rec_idx;
  int                    accepted;
  int                    rec_count;
  int                    cycle;
  int                    errors;
  int                    checked;

  prefetch_buffer u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_o       (instr)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // reporting and reference helpers
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("ERROR t=%0t %s expected %h got %h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic report_fault(input string what);
    $display("ERROR t=%0t %s", $time, what);
    errors++;
  endtask

  // half-word at a byte address of the image, which wraps every 256 bytes
  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = image[int'(a[7:2])];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  //////////////////////////////////////////////////
  // per-cycle drive 1 unit after the rising edge
  //////////////////////////////////////////////////

  task automatic drive_inputs();
    if (need_branch) begin
      // ready stays low in the branch cycle so nothing is taken with it
      branch      = 1'b1;
      branch_addr = next_target;
      instr_ready = 1'b0;
      exp_pc      = next_target;
      need_branch = 1'b0;
    end else begin
      branch      = 1'b0;
      instr_ready = ($urandom % 4) != 0;
    end
    mem_rsp.gnt = ($urandom % 10) < 7;
    // oldest request answers first once its delay has run out
    if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
      mem_rsp.rvalid = 1'b1;
      mem_rsp.rdata  = image[int'(pend_addr[0][7:2])];
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      mem_rsp.rvalid = 1'b0;
      mem_rsp.rdata  = $urandom;
    end
  endtask

  //////////////////////////////////////////////////
  // per-cycle checks at the falling edge
  //////////////////////////////////////////////////

  task automatic check_hold();
    if (hold_armed && !branch) begin
      assert (instr_valid)
        else report_fault("instr_valid_o dropped while instr_ready_i was low");
      assert (instr.addr == held.addr)
        else report_mismatch("instr_o.addr", held.addr, instr.addr);
      // upper half only counts for a full instruction
      if (held.instr[1:0] == 2'b11) begin
        assert (instr.instr == held.instr)
          else report_mismatch("instr_o.instr", held.instr, instr.instr);
      end else begin
        assert (instr.instr[15:0] == held.instr[15:0])
          else report_mismatch("instr_o.instr[15:0]", {16'h0, held.instr[15:0]},
                               {16'h0, instr.instr[15:0]});
      end
    end
    hold_armed = instr_valid && !instr_ready && !branch;
    held       = instr;
  endtask

  task automatic check_accept();
    lo_half = half_at(exp_pc);
    checked++;
    assert (instr.addr == exp_pc)
      else report_mismatch("instr_o.addr", exp_pc, instr.addr);
    if (lo_half[1:0] != 2'b11) begin
      assert (instr.instr[15:0] == lo_half)
        else report_mismatch("instr_o.instr[15:0]", {16'h0, lo_half},
                             {16'h0, instr.instr[15:0]});
      exp_pc = exp_pc + 32'd2;
    end else begin
      exp_word = {half_at(exp_pc + 32'd2), lo_half};
      assert (instr.instr == exp_word)
        else report_mismatch("instr_o.instr", exp_word, instr.instr);
      exp_pc = exp_pc + 32'd4;
    end
    accepted++;
    rec_count = (rec_idx < BRANCH_RECS) ? int'(image[IMAGE_WORDS + 2 * rec_idx]) : FINAL_ACCEPTS;
    if (accepted >= rec_count) begin
      accepted = 0;
      if (rec_idx < BRANCH_RECS) begin
        need_branch = 1'b1;
        next_target = image[IMAGE_WORDS + 2 * rec_idx + 1];
        rec_idx++;
      end else begin
        done = 1'b1;
      end
    end
  endtask

  task automatic observe_cycle();
    logic granted;
    granted = mem_req.req && mem_rsp.gnt;
    if (mem_req.req && !seen_req) begin
      seen_req = 1'b1;
      assert (mem_req.addr == `FETCH_BOOT_ADDR)
        else report_mismatch("mem_req_o.addr", `FETCH_BOOT_ADDR, mem_req.addr);
    end
    if (granted) begin
      pend_addr.push_back(mem_req.addr);
      pend_due.push_back(cycle + 1 + int'($urandom % 3));
    end
    // grants minus responses as seen on the memory port
    in_flight = in_flight + int'(granted) - int'(mem_rsp.rvalid);
    assert (in_flight <= `FETCH_MAX_OUTSTANDING)
      else report_fault($sformatf("%0d requests in flight, above the limit", in_flight));
    check_hold();
    if (instr_valid && instr_ready) begin
      check_accept();
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    // seed once for the whole run
    void'($urandom(32'h17d3cd0b));
    $readmemh("prefetch_input.txt", image);
    clk         = 1'b0;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    mem_rsp     = '0;
    instr_ready = 1'b0;
    in_flight   = 0;
    exp_pc      = `FETCH_BOOT_ADDR;
    next_target = '0;
    held        = '0;
    hold_armed  = 1'b0;
    need_branch = 1'b0;
    seen_req    = 1'b0;
    done        = 1'b0;
    rec_idx     = 0;
    accepted    = 0;
    cycle       = 0;
    errors      = 0;
    checked     = 0;
    repeat (8) begin
      @(negedge clk);
      assert (!mem_req.req) else report_fault("memory request raised during reset");
      assert (!instr_valid) else report_fault("instr_valid_o raised during reset");
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (!done && cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      #1;
      cycle++;
      drive_inputs();
      @(negedge clk);
      observe_cycle();
    end
    if (!done) begin
      report_fault($sformatf("timeout after %0d cycles, %0d of %0d branch records done",
                             cycle, rec_idx, BRANCH_RECS));
    end
    $display("checked %0d instructions, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* prefetch_input.txt */
// memory image: 64 words of 32 bits, four per line, first word at byte address 0x00
// then 8 branch records: instructions to accept before the branch, branch target
// 0x00
45014781 00a50533 05134505 80820015
11410001 c6060613 fe071ee3 40a6853e
47814398 0ff00793 02f50463 95aa8f2e
00f586b3 0785068b 00e68023 bfe50605
// 0x40
71794501 f4226713 d0060613 e0a28082
00c58733 46850ff7 00008067 c4224705
87aa0693 00d7c503 8d0d0ad3 63638082
0000c891 40b505b3 41d3010b 80824501
// 0x80, boot address
11414701 0c134509 00a50533 86b38082
40d50004 05134685 85aa0015 fff50513
0ff0c0d8 45014f83 46050000 00f507b3
c3914781 06138d19 e3990015 8082fe5d
// 0xc0
01134108 f0afff01 11210513 4711051b
8b8d0785 0793c398 00300002 20230505
00b50023 06859742 02a5c463 47858f8f
05058536 07930001 00280e63 fd7ff06f
// branch records
00000006 0000008a
00000004 00000012
00000009 000000c6
00000002 00000040
00000007 000000f2
00000001 0000001e
00000005 000000a6
0000000c 00000080

/* tb.f */
+incdir+.
fetch_pkg.sv
fetch_fifo.sv
fetch_ctrl_fsm.sv
fetch_outstanding_cnt.sv
prefetch_buffer.sv
tb_prefetch_buffer.sv

/* Makefile */
# Verilator build and run of the prefetch buffer testbench

SIM  := obj_dir/Vtb_prefetch_buffer
SRCS := $(filter-out +incdir+%,$(shell cat tb.f)) fetch_defs.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_prefetch_buffer -f tb.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "Simulation finished: PASS" sim.log || (echo "run failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
